// File: testbench/i2s_rx_vectors.txt
// Columns, hex: left sample, decimated value, expected FIFO level after that push
// Row k is frame k of the enabled run and push k into an empty FIFO
a5c3 1e01 0001
8000 2d02 0002
7fff 3c03 0003
0001 4b04 0004
ffff 5a05 0005
1357 6906 0006
2468 7807 0007
f0f0 8708 0008
0f0f 9609 0009
c001 a50a 000a
3ffe b40b 000b
5555 c30c 000c
aaaa d20d 000d
6d4b e10e 000e
92b4 f00f 000f
0c3a 0f10 0010
e7d2 1e11 0010
4a89 2d12 0010

// File: filelist.f
hw/i2s_rx_pkg.sv
hw/i2s_rx_deserializer.sv
hw/predeci_sample_ram.sv
hw/deci_data_fifo.sv
hw/i2s_rx_registers.sv
hw/i2s_slave_rx_top.sv
testbench/tb_i2s_slave_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build the I2S receiver testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_i2s_slave_rx -f filelist.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: testbench/tb_i2s_slave_rx.sv
// Testbench for the I2S slave receiver
// Drives I2S frames, Wishbone cycles and decimator pushes from the vectors file
`timescale 1ns/100ps

module tb_i2s_slave_rx;

	localparam int CLK_PERIOD      = 8;
	localparam int CLK_STOP_LIMIT  = 64;
	localparam int DECI_FIFO_DEPTH = 16;
	localparam int SW              = i2s_rx_pkg::SAMPLE_WIDTH;
	localparam int DW              = i2s_rx_pkg::WB_DAT_WIDTH;
	localparam int AW              = i2s_rx_pkg::WB_ADR_WIDTH;
	localparam int RAM_AW          = i2s_rx_pkg::RAM_ADR_WIDTH;
	// Rows in the vectors file with three words per row
	localparam int NUM_VEC         = 18;
	// Two slots of 16 bits at 8 system clocks per bit
	localparam int FRAME_CYCLES    = 2 * SW * 8;
	localparam int WATCHDOG_NS     = (NUM_VEC + 4) * FRAME_CYCLES * CLK_PERIOD + 40000;
	localparam int ACK_TIMEOUT     = 16;
	localparam logic [DW-1:0] STS_EMPTY = 32'h1 << i2s_rx_pkg::FIFO_EMPTY_BIT;

	logic              wbs_clk = 1'b0;
	logic              reset;
	logic              wbs_cyc;
	logic              wbs_stb;
	logic              wbs_we;
	logic [AW-1:0]     wbs_adr;
	logic [DW-1:0]     wbs_dat_w;
	logic [DW-1:0]     wbs_dat_r;
	logic              wbs_ack;
	logic              sck;
	logic              ws;
	logic              sd;
	logic [RAM_AW-1:0] fir_rd_addr;
	logic [SW-1:0]     fir_deci_data;
	logic              fir_deci_push;
	logic              fir_deci_done;
	logic [SW-1:0]     fir_rd_data;
	logic              fir_ena;
	logic [RAM_AW-1:0] ram_wr_addr;
	logic              ram_wr_ena;
	logic              clock_stopped;
	logic              i2s_en;
	logic              dis_intr;
	logic              con_intr;
	logic              rx_intr;

	// Each row holds a left sample, a decimated value and the FIFO level after its push
	logic [SW-1:0]     vec_mem [0:3*NUM_VEC-1];
	logic [31:0]       lcg_state = 32'h4a89_0edf;
	logic              last_right_lsb = 1'b0;
	int                push_count;
	int                k;
	int                waited;

	always #(CLK_PERIOD / 2) wbs_clk = ~wbs_clk;

	i2s_slave_rx_top #(
		.CLK_STOP_LIMIT  (CLK_STOP_LIMIT),
		.DECI_FIFO_DEPTH (DECI_FIFO_DEPTH)
	) u_i2s_slave_rx_top (
		.wbs_clk_i           (wbs_clk),
		.reset_i             (reset),
		.wbs_cyc_i           (wbs_cyc),
		.wbs_stb_i           (wbs_stb),
		.wbs_we_i            (wbs_we),
		.wbs_adr_i           (wbs_adr),
		.wbs_dat_i           (wbs_dat_w),
		.wbs_dat_o           (wbs_dat_r),
		.wbs_ack_o           (wbs_ack),
		.i2s_sck_i           (sck),
		.i2s_ws_i            (ws),
		.i2s_sd_i            (sd),
		.fir_rd_addr_i       (fir_rd_addr),
		.fir_deci_data_i     (fir_deci_data),
		.fir_deci_push_i     (fir_deci_push),
		.fir_deci_done_i     (fir_deci_done),
		.fir_rd_data_o       (fir_rd_data),
		.fir_ena_o           (fir_ena),
		.ram_wr_addr_o       (ram_wr_addr),
		.ram_wr_ena_o        (ram_wr_ena),
		.i2s_clock_stopped_o (clock_stopped),
		.i2s_en_o            (i2s_en),
		.dis_intr_o          (dis_intr),
		.con_intr_o          (con_intr),
		.rx_intr_o           (rx_intr)
	);

	// Counts sample RAM writes
	always @(posedge wbs_clk) begin
		if (reset)
			push_count <= 0;
		else if (ram_wr_ena)
			push_count <= push_count + 1;
	end

	// ----------------------------------------
	// Failure reporting and compares
	// ----------------------------------------
	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic fail_with_reason(input string why);
		$display("ERROR at %0t: %s", $time, why);
		abort_run();
	endtask

	task automatic check_word(input logic [DW-1:0] act, input logic [DW-1:0] exp,
			input string what);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, act, exp);
			abort_run();
		end
	endtask

	task automatic check_sample(input logic [SW-1:0] act, input logic [SW-1:0] exp,
			input string what);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, act, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input logic [RAM_AW-1:0] act, input logic [RAM_AW-1:0] exp,
			input string what);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, act, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input logic act, input logic exp, input string what);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, what, act, exp);
			abort_run();
		end
	endtask

	// Status word with level, empty and full from the register map
	function automatic logic [DW-1:0] fifo_status(input logic [SW-1:0] level);
		logic [DW-1:0] word;
		word = '0;
		word[8:0] = level[8:0];
		word[i2s_rx_pkg::FIFO_EMPTY_BIT] = (level == '0);
		word[i2s_rx_pkg::FIFO_FULL_BIT]  = (level == SW'(DECI_FIFO_DEPTH));
		return word;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// ----------------------------------------
	// Bus and stimulus tasks
	// ----------------------------------------
	task automatic bus_cycle(input logic we, input logic [AW-1:0] adr,
			input logic [DW-1:0] wdat, output logic [DW-1:0] data);
		int cnt;
		cnt = 0;
		@(posedge wbs_clk);
		#1;
		wbs_cyc   = 1'b1;
		wbs_stb   = 1'b1;
		wbs_we    = we;
		wbs_adr   = adr;
		wbs_dat_w = wdat;
		do begin
			@(posedge wbs_clk);
			#1;
			cnt++;
		end while (!wbs_ack && cnt < ACK_TIMEOUT);
		if (!wbs_ack)
			fail_with_reason("Wishbone acknowledge never arrived");
		data    = wbs_dat_r;
		wbs_cyc = 1'b0;
		wbs_stb = 1'b0;
		wbs_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [AW-1:0] adr, input logic [DW-1:0] wdat);
		logic [DW-1:0] unused;
		bus_cycle(1'b1, adr, wdat, unused);
	endtask

	task automatic wb_read(input logic [AW-1:0] adr, output logic [DW-1:0] data);
		bus_cycle(1'b0, adr, '0, data);
	endtask

	task automatic read_expect(input logic [AW-1:0] adr, input logic [DW-1:0] exp,
			input string what);
		logic [DW-1:0] data;
		wb_read(adr, data);
		check_word(data, exp, what);
	endtask

	// One bit slot with WS and SD changing on the falling edge
	task automatic drive_bit(input logic ws_val, input logic sd_val);
		@(posedge wbs_clk);
		#1;
		sck = 1'b0;
		ws  = ws_val;
		sd  = sd_val;
		repeat (4) @(posedge wbs_clk);
		#1;
		sck = 1'b1;
		repeat (3) @(posedge wbs_clk);
		#1;
	endtask

	// Standard I2S framing with the MSB one bit after the WS change
	task automatic send_frame(input logic [SW-1:0] left, input logic [SW-1:0] right);
		int i;
		logic bit_val;
		for (i = 0; i < 2 * SW; i++) begin
			if (i == 0)
				bit_val = last_right_lsb;
			else if (i <= SW)
				bit_val = left[SW - i];
			else
				bit_val = right[2 * SW - i];
			drive_bit(i >= SW, bit_val);
		end
		last_right_lsb = right[0];
	endtask

	task automatic send_left(input logic [SW-1:0] left);
		lcg_state = lcg_next(lcg_state);
		send_frame(left, lcg_state[31:16]);
	endtask

	task automatic push_deci(input logic [SW-1:0] value);
		@(posedge wbs_clk);
		#1;
		fir_deci_push = 1'b1;
		fir_deci_data = value;
		@(posedge wbs_clk);
		#1;
		fir_deci_push = 1'b0;
	endtask

	initial begin
		#(WATCHDOG_NS);
		fail_with_reason("Watchdog expired before the test sequence finished");
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		reset = 1'b1;
		wbs_cyc = 1'b0;
		wbs_stb = 1'b0;
		wbs_we = 1'b0;
		wbs_adr = '0;
		wbs_dat_w = '0;
		sck = 1'b0;
		ws = 1'b1;
		sd = 1'b0;
		fir_rd_addr = '0;
		fir_deci_data = '0;
		fir_deci_push = 1'b0;
		fir_deci_done = 1'b0;
		$readmemh("testbench/i2s_rx_vectors.txt", vec_mem);
		repeat (3) @(posedge wbs_clk);
		#1;
		reset = 1'b0;

		// Reset values
		check_bit(clock_stopped, 1'b1, "clock stop flag after reset");
		read_expect(i2s_rx_pkg::ADR_I2S_EN, '0, "enable after reset");
		read_expect(i2s_rx_pkg::ADR_INTR_STS, '0, "interrupt status after reset");
		read_expect(i2s_rx_pkg::ADR_INTR_EN, '0, "interrupt enable after reset");
		read_expect(i2s_rx_pkg::ADR_FIFO_STS, STS_EMPTY, "FIFO status after reset");
		read_expect(i2s_rx_pkg::ADR_FIFO_DATA, '0, "FIFO data after reset");
		read_expect(i2s_rx_pkg::ADR_FIFO_RST, '0, "flush register after reset");
		read_expect(i2s_rx_pkg::ADR_FIR_CTRL, '0, "FIR control after reset");
		read_expect(10'd9, i2s_rx_pkg::DEF_REG_VALUE, "undefined address");
		read_expect(10'h3ff, i2s_rx_pkg::DEF_REG_VALUE, "top undefined address");
		wb_write(i2s_rx_pkg::ADR_FIR_CTRL, 32'h1);
		read_expect(i2s_rx_pkg::ADR_FIR_CTRL, 32'h1, "FIR control readback");
		check_bit(fir_ena, 1'b1, "FIR enable output set");
		wb_write(i2s_rx_pkg::ADR_FIR_CTRL, 32'h0);
		check_bit(fir_ena, 1'b0, "FIR enable output cleared");
		wb_write(i2s_rx_pkg::ADR_I2S_EN, 32'h1);
		read_expect(i2s_rx_pkg::ADR_I2S_EN, 32'h1, "enable readback");
		check_bit(i2s_en, 1'b1, "receiver enable output");
		wb_write(i2s_rx_pkg::ADR_I2S_EN, 32'h0);
		wb_write(i2s_rx_pkg::ADR_INTR_EN, 32'h7);
		read_expect(i2s_rx_pkg::ADR_INTR_EN, 32'h7, "interrupt enable readback");
		wb_write(i2s_rx_pkg::ADR_INTR_EN, 32'h0);

		// Frames while disabled leave the RAM alone
		send_left(16'h1234);
		send_left(16'hbeef);
		if (push_count != 0)
			fail_with_reason("Sample RAM was written while the receiver was disabled");
		check_addr(ram_wr_addr, '0, "write pointer while disabled");

		// Enabled frames fill the sample RAM in order
		wb_write(i2s_rx_pkg::ADR_I2S_EN, 32'h1);
		for (k = 0; k < NUM_VEC; k++)
			send_left(vec_mem[3*k]);
		if (push_count != NUM_VEC)
			fail_with_reason("Number of sample RAM writes differs from frames sent");
		check_addr(ram_wr_addr, RAM_AW'(NUM_VEC), "write pointer after frames");
		for (k = 0; k < NUM_VEC; k++) begin
			@(posedge wbs_clk);
			#1;
			fir_rd_addr = RAM_AW'(k);
			@(posedge wbs_clk);
			#1;
			check_sample(fir_rd_data, vec_mem[3*k], "sample RAM word");
		end

		// Disable returns the write pointer to the ring start
		wb_write(i2s_rx_pkg::ADR_I2S_EN, 32'h0);
		@(posedge wbs_clk);
		#1;
		check_addr(ram_wr_addr, '0, "write pointer after disable");

		// Decimated FIFO short run then overfill
		for (k = 0; k < 4; k++) begin
			push_deci(vec_mem[3*k+1]);
			read_expect(i2s_rx_pkg::ADR_FIFO_STS, fifo_status(vec_mem[3*k+2]),
				"FIFO level");
		end
		for (k = 0; k < 4; k++)
			read_expect(i2s_rx_pkg::ADR_FIFO_DATA, {16'h0, vec_mem[3*k+1]},
				"FIFO pop order");
		read_expect(i2s_rx_pkg::ADR_FIFO_DATA, '0, "pop of empty FIFO");
		read_expect(i2s_rx_pkg::ADR_FIFO_STS, STS_EMPTY, "FIFO drained");
		for (k = 0; k < NUM_VEC; k++) begin
			push_deci(vec_mem[3*k+1]);
			read_expect(i2s_rx_pkg::ADR_FIFO_STS, fifo_status(vec_mem[3*k+2]),
				"FIFO fill level");
		end
		for (k = 0; k < DECI_FIFO_DEPTH; k++)
			read_expect(i2s_rx_pkg::ADR_FIFO_DATA, {16'h0, vec_mem[3*k+1]},
				"FIFO full pop");
		read_expect(i2s_rx_pkg::ADR_FIFO_DATA, '0, "pop after overfill");

		// Flush
		for (k = 0; k < 5; k++)
			push_deci(vec_mem[3*k+1]);
		read_expect(i2s_rx_pkg::ADR_FIFO_STS, fifo_status(vec_mem[3*4+2]),
			"level before flush");
		wb_write(i2s_rx_pkg::ADR_FIFO_RST, 32'h1);
		read_expect(i2s_rx_pkg::ADR_FIFO_STS, STS_EMPTY, "FIFO status after flush");

		// Clock stop and restart interrupts
		wb_write(i2s_rx_pkg::ADR_INTR_EN, 32'h3);
		send_left(vec_mem[0]);
		if (push_count != NUM_VEC)
			fail_with_reason("Sample RAM was written after the receiver was disabled");
		wb_write(i2s_rx_pkg::ADR_INTR_STS, 32'h7);
		check_bit(clock_stopped, 1'b0, "clock stop flag while running");
		check_bit(dis_intr, 1'b0, "disconnect interrupt while running");
		repeat (CLK_STOP_LIMIT + 10) @(posedge wbs_clk);
		#1;
		check_bit(clock_stopped, 1'b1, "clock stop flag after idle");
		check_bit(dis_intr, 1'b1, "disconnect interrupt");
		check_bit(con_intr, 1'b0, "connect interrupt while stopped");
		wb_write(i2s_rx_pkg::ADR_INTR_STS, 32'h1);
		check_bit(dis_intr, 1'b0, "disconnect interrupt cleared");
		drive_bit(1'b1, 1'b0);
		waited = 0;
		do begin
			@(posedge wbs_clk);
			#1;
			waited++;
		end while (!con_intr && waited < 20);
		check_bit(con_intr, 1'b1, "connect interrupt");
		check_bit(clock_stopped, 1'b0, "clock stop flag after restart");
		wb_write(i2s_rx_pkg::ADR_INTR_STS, 32'h2);
		check_bit(con_intr, 1'b0, "connect interrupt cleared");
		// Masked output while the status still records the stop
		wb_write(i2s_rx_pkg::ADR_INTR_EN, 32'h0);
		repeat (CLK_STOP_LIMIT + 10) @(posedge wbs_clk);
		#1;
		check_bit(clock_stopped, 1'b1, "clock stop flag again");
		check_bit(dis_intr, 1'b0, "masked disconnect interrupt");
		read_expect(i2s_rx_pkg::ADR_INTR_STS, 32'h1, "masked disconnect status");

		// Decimation done
		wb_write(i2s_rx_pkg::ADR_INTR_STS, 32'h7);
		wb_write(i2s_rx_pkg::ADR_INTR_EN, 32'h4);
		@(posedge wbs_clk);
		#1;
		fir_deci_done = 1'b1;
		@(posedge wbs_clk);
		#1;
		fir_deci_done = 1'b0;
		waited = 0;
		do begin
			@(posedge wbs_clk);
			#1;
			waited++;
		end while (!rx_intr && waited < 20);
		check_bit(rx_intr, 1'b1, "decimation done interrupt");
		read_expect(i2s_rx_pkg::ADR_INTR_STS, 32'h4, "decimation done status");
		wb_write(i2s_rx_pkg::ADR_INTR_STS, 32'h4);
		check_bit(rx_intr, 1'b0, "decimation done cleared");

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: hw/i2s_slave_rx_top.sv
// I2S slave receiver top level
// Deserializer, sample RAM, decimated FIFO and Wishbone registers
`timescale 1ns/100ps

module i2s_slave_rx_top #(
	parameter int CLK_STOP_LIMIT  = 64,
	parameter int DECI_FIFO_DEPTH = 16
) (
	input  logic                                 wbs_clk_i,
	input  logic                                 reset_i,
	// Wishbone slave
	input  logic                                 wbs_cyc_i,
	input  logic                                 wbs_stb_i,
	input  logic                                 wbs_we_i,
	input  logic [i2s_rx_pkg::WB_ADR_WIDTH-1:0]  wbs_adr_i,
	input  logic [i2s_rx_pkg::WB_DAT_WIDTH-1:0]  wbs_dat_i,
	output logic [i2s_rx_pkg::WB_DAT_WIDTH-1:0]  wbs_dat_o,
	output logic                                 wbs_ack_o,
	// I2S lines
	input  logic                                 i2s_sck_i,
	input  logic                                 i2s_ws_i,
	input  logic                                 i2s_sd_i,
	// FIR decimator side
	input  logic [i2s_rx_pkg::RAM_ADR_WIDTH-1:0] fir_rd_addr_i,
	input  logic [i2s_rx_pkg::SAMPLE_WIDTH-1:0]  fir_deci_data_i,
	input  logic                                 fir_deci_push_i,
	input  logic                                 fir_deci_done_i,
	output logic [i2s_rx_pkg::SAMPLE_WIDTH-1:0]  fir_rd_data_o,
	output logic                                 fir_ena_o,
	output logic [i2s_rx_pkg::RAM_ADR_WIDTH-1:0] ram_wr_addr_o,
	output logic                                 ram_wr_ena_o,
	// Status and interrupts
	output logic                                 i2s_clock_stopped_o,
	output logic                                 i2s_en_o,
	output logic                                 dis_intr_o,
	output logic                                 con_intr_o,
	output logic                                 rx_intr_o
);

	logic [i2s_rx_pkg::SAMPLE_WIDTH-1:0]   sample;
	logic                                  sample_push;
	logic                                  fifo_pop;
	logic                                  fifo_flush;
	logic [i2s_rx_pkg::SAMPLE_WIDTH-1:0]   fifo_data;
	logic [i2s_rx_pkg::FIFO_LVL_WIDTH-1:0] fifo_level;
	logic                                  fifo_empty;
	logic                                  fifo_full;

	// ----------------------------------------
	// Input side
	// ----------------------------------------
	i2s_rx_deserializer #(
		.CLK_STOP_LIMIT  (CLK_STOP_LIMIT)
	) u_deserializer (
		.wbs_clk_i       (wbs_clk_i),
		.reset_i         (reset_i),
		.i2s_sck_i       (i2s_sck_i),
		.i2s_ws_i        (i2s_ws_i),
		.i2s_sd_i        (i2s_sd_i),
		.i2s_en_i        (i2s_en_o),
		.sample_o        (sample),
		.push_o          (sample_push),
		.clock_stopped_o (i2s_clock_stopped_o)
	);

	// Left samples for the decimator
	predeci_sample_ram u_sample_ram (
		.wbs_clk_i     (wbs_clk_i),
		.reset_i       (reset_i),
		.i2s_en_i      (i2s_en_o),
		.sample_i      (sample),
		.push_i        (sample_push),
		.fir_rd_addr_i (fir_rd_addr_i),
		.fir_rd_data_o (fir_rd_data_o),
		.wr_addr_o     (ram_wr_addr_o),
		.wr_ena_o      (ram_wr_ena_o)
	);

	// ----------------------------------------
	// Output side
	// ----------------------------------------
	deci_data_fifo #(
		.DECI_FIFO_DEPTH (DECI_FIFO_DEPTH)
	) u_deci_fifo (
		.wbs_clk_i (wbs_clk_i),
		.reset_i   (reset_i),
		.push_i    (fir_deci_push_i),
		.data_i    (fir_deci_data_i),
		.pop_i     (fifo_pop),
		.flush_i   (fifo_flush),
		.rd_data_o (fifo_data),
		.level_o   (fifo_level),
		.empty_o   (fifo_empty),
		.full_o    (fifo_full)
	);

	i2s_rx_registers u_registers (
		.wbs_clk_i       (wbs_clk_i),
		.reset_i         (reset_i),
		.wbs_cyc_i       (wbs_cyc_i),
		.wbs_stb_i       (wbs_stb_i),
		.wbs_we_i        (wbs_we_i),
		.wbs_adr_i       (wbs_adr_i),
		.wbs_dat_i       (wbs_dat_i),
		.clock_stopped_i (i2s_clock_stopped_o),
		.fir_deci_done_i (fir_deci_done_i),
		.fifo_data_i     (fifo_data),
		.fifo_level_i    (fifo_level),
		.fifo_empty_i    (fifo_empty),
		.fifo_full_i     (fifo_full),
		.wbs_dat_o       (wbs_dat_o),
		.wbs_ack_o       (wbs_ack_o),
		.i2s_en_o        (i2s_en_o),
		.fir_ena_o       (fir_ena_o),
		.fifo_pop_o      (fifo_pop),
		.fifo_flush_o    (fifo_flush),
		.dis_intr_o      (dis_intr_o),
		.con_intr_o      (con_intr_o),
		.rx_intr_o       (rx_intr_o)
	);

endmodule

// File: hw/i2s_rx_registers.sv
// I2S receiver register block
// Wishbone decode, control bits, sticky interrupt status and FIFO pop
`timescale 1ns/100ps

module i2s_rx_registers (
	input  logic                                  wbs_clk_i,
	input  logic                                  reset_i,
	input  logic                                  wbs_cyc_i,
	input  logic                                  wbs_stb_i,
	input  logic                                  wbs_we_i,
	input  logic [i2s_rx_pkg::WB_ADR_WIDTH-1:0]   wbs_adr_i,
	input  logic [i2s_rx_pkg::WB_DAT_WIDTH-1:0]   wbs_dat_i,
	input  logic                                  clock_stopped_i,
	input  logic                                  fir_deci_done_i,
	input  logic [i2s_rx_pkg::SAMPLE_WIDTH-1:0]   fifo_data_i,
	input  logic [i2s_rx_pkg::FIFO_LVL_WIDTH-1:0] fifo_level_i,
	input  logic                                  fifo_empty_i,
	input  logic                                  fifo_full_i,
	output logic [i2s_rx_pkg::WB_DAT_WIDTH-1:0]   wbs_dat_o,
	output logic                                  wbs_ack_o,
	output logic                                  i2s_en_o,
	output logic                                  fir_ena_o,
	output logic                                  fifo_pop_o,
	output logic                                  fifo_flush_o,
	output logic                                  dis_intr_o,
	output logic                                  con_intr_o,
	output logic                                  rx_intr_o
);

	localparam int DW = i2s_rx_pkg::WB_DAT_WIDTH;
	localparam int SW = i2s_rx_pkg::SAMPLE_WIDTH;
	localparam int LW = i2s_rx_pkg::FIFO_LVL_WIDTH;
	localparam int IW = i2s_rx_pkg::INTR_WIDTH;

	logic          access;
	logic          rd_access;
	logic          wr_access;
	logic          ack_q;
	logic [DW-1:0] rd_mux;
	logic [DW-1:0] rd_data_q;
	logic          i2s_en_q;
	logic          fir_ena_q;
	logic [IW-1:0] intr_sts_q;
	logic [IW-1:0] intr_en_q;
	logic [IW-1:0] intr_set;
	logic [IW-1:0] intr_clr;
	logic          stop_last_q;

	// ----------------------------------------
	// Bus access
	// ----------------------------------------
	// New access only while no ack is pending
	assign access    = wbs_cyc_i & wbs_stb_i & ~ack_q;
	assign rd_access = access & ~wbs_we_i;
	assign wr_access = access & wbs_we_i;

	// Pop in the access cycle, head word is latched alongside
	assign fifo_pop_o   = rd_access & (wbs_adr_i == i2s_rx_pkg::ADR_FIFO_DATA) & ~fifo_empty_i;
	assign fifo_flush_o = wr_access & (wbs_adr_i == i2s_rx_pkg::ADR_FIFO_RST) & wbs_dat_i[0];

	// Read data select
	always_comb begin
		rd_mux = '0;
		case (wbs_adr_i)
			i2s_rx_pkg::ADR_I2S_EN:   rd_mux[0] = i2s_en_q;
			i2s_rx_pkg::ADR_INTR_STS: rd_mux[IW-1:0] = intr_sts_q;
			i2s_rx_pkg::ADR_INTR_EN:  rd_mux[IW-1:0] = intr_en_q;
			i2s_rx_pkg::ADR_FIFO_STS: begin
				rd_mux[LW-1:0]                     = fifo_level_i;
				rd_mux[i2s_rx_pkg::FIFO_EMPTY_BIT] = fifo_empty_i;
				rd_mux[i2s_rx_pkg::FIFO_FULL_BIT]  = fifo_full_i;
			end
			// Empty FIFO reads as zero
			i2s_rx_pkg::ADR_FIFO_DATA: begin
				if (!fifo_empty_i)
					rd_mux[SW-1:0] = fifo_data_i;
			end
			// Flush register is write-only
			i2s_rx_pkg::ADR_FIFO_RST: rd_mux = '0;
			i2s_rx_pkg::ADR_FIR_CTRL: rd_mux[0] = fir_ena_q;
			default:                  rd_mux = i2s_rx_pkg::DEF_REG_VALUE;
		endcase
	end

	always_ff @(posedge wbs_clk_i) begin
		if (rd_access)
			rd_data_q <= rd_mux;
	end

	// ----------------------------------------
	// Interrupt sources
	// ----------------------------------------
	always_comb begin
		intr_set = '0;
		intr_set[i2s_rx_pkg::INTR_DIS_BIT]  = clock_stopped_i & ~stop_last_q;
		intr_set[i2s_rx_pkg::INTR_CON_BIT]  = ~clock_stopped_i & stop_last_q;
		intr_set[i2s_rx_pkg::INTR_DONE_BIT] = fir_deci_done_i;
	end

	// Write 1 to clear
	assign intr_clr = (wr_access && wbs_adr_i == i2s_rx_pkg::ADR_INTR_STS) ?
		wbs_dat_i[IW-1:0] : '0;

	// ----------------------------------------
	// Control state
	// ----------------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (reset_i) begin
			ack_q       <= 1'b0;
			i2s_en_q    <= 1'b0;
			fir_ena_q   <= 1'b0;
			intr_en_q   <= i2s_rx_pkg::INTR_RST_VALUE;
			intr_sts_q  <= i2s_rx_pkg::INTR_RST_VALUE;
			// Stop flag comes out of reset high, no edge there
			stop_last_q <= 1'b1;
		end else begin
			ack_q       <= access;
			stop_last_q <= clock_stopped_i;
			// New event wins over a clear in the same cycle
			intr_sts_q  <= (intr_sts_q & ~intr_clr) | intr_set;
			if (wr_access) begin
				case (wbs_adr_i)
					i2s_rx_pkg::ADR_I2S_EN:   i2s_en_q  <= wbs_dat_i[0];
					i2s_rx_pkg::ADR_INTR_EN:  intr_en_q <= wbs_dat_i[IW-1:0];
					i2s_rx_pkg::ADR_FIR_CTRL: fir_ena_q <= wbs_dat_i[0];
					default: ;
				endcase
			end
		end
	end

	assign wbs_dat_o = rd_data_q;
	assign wbs_ack_o = ack_q;
	assign i2s_en_o  = i2s_en_q;
	assign fir_ena_o = fir_ena_q;

	// Masked interrupt lines
	assign dis_intr_o = intr_sts_q[i2s_rx_pkg::INTR_DIS_BIT] & intr_en_q[i2s_rx_pkg::INTR_DIS_BIT];
	assign con_intr_o = intr_sts_q[i2s_rx_pkg::INTR_CON_BIT] & intr_en_q[i2s_rx_pkg::INTR_CON_BIT];
	assign rx_intr_o  = intr_sts_q[i2s_rx_pkg::INTR_DONE_BIT] &
		intr_en_q[i2s_rx_pkg::INTR_DONE_BIT];

endmodule

// File: hw/deci_data_fifo.sv
// Decimated data FIFO
// Holds FIR results until software pops them, head word always visible
`timescale 1ns/100ps

module deci_data_fifo #(
	parameter int DECI_FIFO_DEPTH = 16
) (
	input  logic                                  wbs_clk_i,
	input  logic                                  reset_i,
	input  logic                                  push_i,
	input  logic [i2s_rx_pkg::SAMPLE_WIDTH-1:0]   data_i,
	input  logic                                  pop_i,
	input  logic                                  flush_i,
	output logic [i2s_rx_pkg::SAMPLE_WIDTH-1:0]   rd_data_o,
	output logic [i2s_rx_pkg::FIFO_LVL_WIDTH-1:0] level_o,
	output logic                                  empty_o,
	output logic                                  full_o
);

	localparam int SW        = i2s_rx_pkg::SAMPLE_WIDTH;
	localparam int LW        = i2s_rx_pkg::FIFO_LVL_WIDTH;
	localparam int PTR_WIDTH = $clog2(DECI_FIFO_DEPTH);

	logic [SW-1:0]        mem [DECI_FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr_q;
	logic [PTR_WIDTH-1:0] rd_ptr_q;
	logic [LW-1:0]        level_q;
	logic                 wr_en;
	logic                 rd_en;

	// Push while full is lost, no back-pressure to the decimator
	assign wr_en = push_i & ~full_o;
	assign rd_en = pop_i & ~empty_o;

	always_ff @(posedge wbs_clk_i) begin
		if (wr_en)
			mem[wr_ptr_q] <= data_i;
	end

	// ----------------------------------------
	// Pointers and level
	// ----------------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (reset_i || flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q  <= '0;
		end else begin
			// Power-of-two depth, pointers wrap by width
			if (wr_en)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (rd_en)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   level_q <= level_q + 1'b1;
				2'b01:   level_q <= level_q - 1'b1;
				default: level_q <= level_q;
			endcase
		end
	end

	// Head word, valid whenever not empty
	assign rd_data_o = mem[rd_ptr_q];
	assign level_o   = level_q;
	assign empty_o   = (level_q == '0);
	assign full_o    = (level_q == LW'(DECI_FIFO_DEPTH));

endmodule

// File: hw/predeci_sample_ram.sv
// Pre-decimation sample RAM
// Ring of left samples written by the receiver, read by the FIR decimator
`timescale 1ns/100ps

module predeci_sample_ram (
	input  logic                                 wbs_clk_i,
	input  logic                                 reset_i,
	input  logic                                 i2s_en_i,
	input  logic [i2s_rx_pkg::SAMPLE_WIDTH-1:0]  sample_i,
	input  logic                                 push_i,
	input  logic [i2s_rx_pkg::RAM_ADR_WIDTH-1:0] fir_rd_addr_i,
	output logic [i2s_rx_pkg::SAMPLE_WIDTH-1:0]  fir_rd_data_o,
	output logic [i2s_rx_pkg::RAM_ADR_WIDTH-1:0] wr_addr_o,
	output logic                                 wr_ena_o
);

	localparam int SW        = i2s_rx_pkg::SAMPLE_WIDTH;
	localparam int AW        = i2s_rx_pkg::RAM_ADR_WIDTH;
	localparam int RAM_DEPTH = 1 << AW;

	logic [SW-1:0] mem [RAM_DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [SW-1:0] rd_data_q;

	// Write pointer, wraps at 512 by width
	always_ff @(posedge wbs_clk_i) begin
		if (reset_i)
			wr_ptr_q <= '0;
		else if (!i2s_en_i)
			// Held at the ring start while the receiver is off
			wr_ptr_q <= '0;
		else if (push_i)
			wr_ptr_q <= wr_ptr_q + 1'b1;
	end

	// Sample write port
	always_ff @(posedge wbs_clk_i) begin
		if (push_i)
			mem[wr_ptr_q] <= sample_i;
	end

	// FIR read port, one cycle latency
	always_ff @(posedge wbs_clk_i) begin
		rd_data_q <= mem[fir_rd_addr_i];
	end

	assign fir_rd_data_o = rd_data_q;
	// Decimator tracks fill from these two
	assign wr_addr_o     = wr_ptr_q;
	assign wr_ena_o      = push_i;

endmodule

// File: hw/i2s_rx_deserializer.sv
// I2S slave deserializer
// Oversamples the I2S lines in the bus clock, shifts in left samples
// and flags a stopped bit clock
`timescale 1ns/100ps

module i2s_rx_deserializer #(
	parameter int CLK_STOP_LIMIT = 64
) (
	input  logic                                wbs_clk_i,
	input  logic                                reset_i,
	input  logic                                i2s_sck_i,
	input  logic                                i2s_ws_i,
	input  logic                                i2s_sd_i,
	input  logic                                i2s_en_i,
	output logic [i2s_rx_pkg::SAMPLE_WIDTH-1:0] sample_o,
	output logic                                push_o,
	output logic                                clock_stopped_o
);

	localparam int SW        = i2s_rx_pkg::SAMPLE_WIDTH;
	localparam int CNT_WIDTH = $clog2(CLK_STOP_LIMIT + 1);

	// Two-flop synchronizers, bit 1 is the safe copy
	logic [1:0]           sck_sync_q;
	logic [1:0]           ws_sync_q;
	logic [1:0]           sd_sync_q;
	logic                 sck_last_q;
	logic                 sck_rise;
	// Word select seen at the previous rise
	logic                 ws_last_q;
	logic [SW-1:0]        shift_q;
	logic [SW-1:0]        shift_nxt;
	logic                 left_done;
	logic [SW-1:0]        sample_q;
	logic                 push_q;
	logic [CNT_WIDTH-1:0] idle_cnt_q;

	// ----------------------------------------
	// Synchronizers and edge detect
	// ----------------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (reset_i) begin
			sck_sync_q <= '0;
			ws_sync_q  <= '0;
			sd_sync_q  <= '0;
			sck_last_q <= 1'b0;
		end else begin
			sck_sync_q <= {sck_sync_q[0], i2s_sck_i};
			ws_sync_q  <= {ws_sync_q[0], i2s_ws_i};
			sd_sync_q  <= {sd_sync_q[0], i2s_sd_i};
			sck_last_q <= sck_sync_q[1];
		end
	end

	// Rise seen one cycle after the synchronizer
	assign sck_rise = sck_sync_q[1] & ~sck_last_q;

	// ----------------------------------------
	// Shift register and word framing
	// ----------------------------------------
	assign shift_nxt = {shift_q[SW-2:0], sd_sync_q[1]};

	// WS change with one-bit delay, new WS high closes the left slot
	assign left_done = sck_rise & (ws_sync_q[1] != ws_last_q) & ws_sync_q[1];

	always_ff @(posedge wbs_clk_i) begin
		if (sck_rise)
			shift_q <= shift_nxt;
		// Right slot words are shifted through and never captured
		if (left_done)
			sample_q <= shift_nxt;
	end

	always_ff @(posedge wbs_clk_i) begin
		if (reset_i) begin
			// Start as if inside a right slot, no bogus first word
			ws_last_q <= 1'b1;
			push_q    <= 1'b0;
		end else begin
			if (sck_rise)
				ws_last_q <= ws_sync_q[1];
			push_q <= left_done & i2s_en_i;
		end
	end

	// ----------------------------------------
	// Bit clock watchdog
	// ----------------------------------------
	// Saturating count of cycles since the last rise
	always_ff @(posedge wbs_clk_i) begin
		if (reset_i)
			idle_cnt_q <= CNT_WIDTH'(CLK_STOP_LIMIT);
		else if (sck_rise)
			idle_cnt_q <= '0;
		else if (idle_cnt_q != CNT_WIDTH'(CLK_STOP_LIMIT))
			idle_cnt_q <= idle_cnt_q + 1'b1;
	end

	assign clock_stopped_o = (idle_cnt_q == CNT_WIDTH'(CLK_STOP_LIMIT));
	assign sample_o        = sample_q;
	assign push_o          = push_q;

endmodule

// File: hw/i2s_rx_pkg.sv
// I2S receiver shared definitions
// Register map, bus and sample widths, bit positions and reset values
package i2s_rx_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	// One I2S channel slot, also one stored sample
	localparam int SAMPLE_WIDTH   = 16;
	// Word address of the register space
	localparam int WB_ADR_WIDTH   = 10;
	localparam int WB_DAT_WIDTH   = 32;
	// 512-word pre-decimation RAM
	localparam int RAM_ADR_WIDTH  = 9;
	// Level field of the FIFO status word
	localparam int FIFO_LVL_WIDTH = 9;
	// Disconnect, connect, decimation done
	localparam int INTR_WIDTH     = 3;

	// ----------------------------------------
	// Register addresses
	// ----------------------------------------
	localparam logic [WB_ADR_WIDTH-1:0] ADR_I2S_EN    = 10'd0;
	localparam logic [WB_ADR_WIDTH-1:0] ADR_INTR_STS  = 10'd2;
	localparam logic [WB_ADR_WIDTH-1:0] ADR_INTR_EN   = 10'd3;
	localparam logic [WB_ADR_WIDTH-1:0] ADR_FIFO_STS  = 10'd4;
	localparam logic [WB_ADR_WIDTH-1:0] ADR_FIFO_DATA = 10'd5;
	localparam logic [WB_ADR_WIDTH-1:0] ADR_FIFO_RST  = 10'd7;
	localparam logic [WB_ADR_WIDTH-1:0] ADR_FIR_CTRL  = 10'd12;

	// Interrupt bit positions, same in status and enable
	localparam int INTR_DIS_BIT  = 0;
	localparam int INTR_CON_BIT  = 1;
	localparam int INTR_DONE_BIT = 2;

	// FIFO status flags
	localparam int FIFO_EMPTY_BIT = 16;
	localparam int FIFO_FULL_BIT  = 17;

	// Marker for reads of unmapped addresses
	localparam logic [WB_DAT_WIDTH-1:0] DEF_REG_VALUE  = 32'hDADDEFAC;
	localparam logic [INTR_WIDTH-1:0]   INTR_RST_VALUE = '0;

endpackage
